/* Bender.yml */
package:
  name: jpeg_dht

sources:
  - files:
      - design/jpeg_dht_pkg.sv
      - design/dht_cfg_decode.sv
      - design/dht_code_match.sv
      - design/dht_symbol_result.sv
      - design/jpeg_dht.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/jpeg_dht_properties.sv
      - verif/jpeg_dht_tb.sv

/* design/dht_cfg_decode.sv */
module dht_cfg_decode
    import jpeg_dht_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     cfg_valid_i,
    input  sym_t     cfg_data_i,
    input  logic     cfg_last_i,
    output logic     cfg_accept_o,
    output logic     tbl_wr_o,
    output tbl_sel_t tbl_wr_sel_o,
    output len_idx_t tbl_wr_len_o,
    output code_t    tbl_wr_min_o,
    output code_t    tbl_wr_max_o,
    output ptr_t     tbl_wr_ptr_o,
    output logic     sym_wr_o,
    output ptr_t     sym_wr_addr_o,
    output sym_t     sym_wr_data_o
);

    logic [IDX_W-1:0]       idx_q;
    tbl_sel_t               table_q;
    sym_t                   cnt_q [NUM_LENGTHS];
    logic [NUM_LENGTHS-1:0] has_q;
    logic [IDX_W-1:0]       total_q;
    len_idx_t               len_q;
    sym_t                   j_q;
    code_t                  code_q;
    ptr_t                   ptr_q;

    logic hdr_w;
    logic cnt_phase_w;
    logic sym_phase_w;
    logic take_w;
    logic eot_w;

    // ------------------------------
    // Stream position
    // ------------------------------
    assign hdr_w       = (idx_q == IDX_IDLE);
    assign cnt_phase_w = (idx_q < IDX_W'(NUM_LENGTHS));
    assign sym_phase_w = !hdr_w && !cnt_phase_w;
    assign take_w      = cfg_valid_i && cfg_accept_o;

    // Table ends on its last symbol, or early on cfg_last_i
    assign eot_w = cfg_last_i || (sym_phase_w && total_q == idx_q);

    // Stall while stepping over empty code lengths
    assign cfg_accept_o = hdr_w || cnt_phase_w || has_q[len_q];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            idx_q <= IDX_IDLE;
        else if (take_w && eot_w)
            idx_q <= IDX_IDLE;
        else if (take_w)
            idx_q <= idx_q + IDX_W'(1);
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            table_q <= TBL_Y_DC;
        else if (take_w && hdr_w)
        begin
            case (cfg_data_i)
                DHT_ID_Y_DC:  table_q <= TBL_Y_DC;
                DHT_ID_Y_AC:  table_q <= TBL_Y_AC;
                DHT_ID_CX_DC: table_q <= TBL_CX_DC;
                DHT_ID_CX_AC: table_q <= TBL_CX_AC;
                // Unknown ids land in chroma AC
                default:      table_q <= TBL_CX_AC;
            endcase
        end
    end

    // ------------------------------
    // Length counts
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (take_w && cnt_phase_w)
            cnt_q[len_idx_t'(idx_q)] <= cfg_data_i;
    end

    // Total starts at 15 so it lines up with the symbol byte index
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            has_q   <= '0;
            total_q <= IDX_W'(NUM_LENGTHS - 1);
        end
        else if (take_w && cnt_phase_w)
        begin
            has_q[len_idx_t'(idx_q)] <= (cfg_data_i != '0);
            total_q                  <= total_q + IDX_W'(cfg_data_i);
        end
        else if (take_w && eot_w)
        begin
            has_q   <= '0;
            total_q <= IDX_W'(NUM_LENGTHS - 1);
        end
    end

    // ------------------------------
    // Canonical code generation
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !sym_phase_w)
        begin
            len_q  <= '0;
            j_q    <= '0;
            code_q <= '0;
        end
        else if (take_w)
        begin
            if (j_q + 8'd1 == cnt_q[len_q])
            begin
                j_q    <= '0;
                len_q  <= len_q + len_idx_t'(1);
                code_q <= (code_q + code_t'(1)) << 1;
            end
            else
            begin
                j_q    <= j_q + 8'd1;
                code_q <= code_q + code_t'(1);
            end
        end
        else if (cfg_valid_i)
        begin
            // Empty length, one per cycle
            len_q  <= len_q + len_idx_t'(1);
            code_q <= code_q << 1;
        end
    end

    // Symbol RAM write pointer, shared by all tables
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            ptr_q <= '0;
        else if (take_w && sym_phase_w)
            ptr_q <= ptr_q + ptr_t'(1);
    end

    // Bounds are written on the first symbol of a length
    assign tbl_wr_o     = take_w && sym_phase_w && (j_q == '0);
    assign tbl_wr_sel_o = table_q;
    assign tbl_wr_len_o = len_q;
    assign tbl_wr_min_o = code_q;
    assign tbl_wr_max_o = code_q + code_t'(cnt_q[len_q]);
    assign tbl_wr_ptr_o = ptr_q;

    assign sym_wr_o      = take_w && sym_phase_w;
    assign sym_wr_addr_o = ptr_q;
    assign sym_wr_data_o = cfg_data_i;

endmodule

/* design/dht_code_match.sv */
module dht_code_match
    import jpeg_dht_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     tbl_wr_i,
    input  tbl_sel_t tbl_wr_sel_i,
    input  len_idx_t tbl_wr_len_i,
    input  code_t    tbl_wr_min_i,
    input  code_t    tbl_wr_max_i,
    input  ptr_t     tbl_wr_ptr_i,
    input  logic     lookup_req_i,
    input  tbl_sel_t lookup_table_i,
    input  code_t    lookup_input_i,
    output logic     lk_valid_o,
    output ptr_t     lk_addr_o,
    output len_idx_t lk_len_o
);

    // Per table, per length bounds
    code_t min_q [4][NUM_LENGTHS];
    code_t max_q [4][NUM_LENGTHS];
    ptr_t  ptr_q [4][NUM_LENGTHS];

    len_idx_t len_r;
    code_t    top_r;
    code_t    addr_r;

    logic     lk_valid_q;
    ptr_t     lk_addr_q;
    len_idx_t lk_len_q;

    // ------------------------------
    // Bound storage
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int t = 0; t < 4; t++)
            begin
                for (int l = 0; l < NUM_LENGTHS; l++)
                begin
                    min_q[t][l] <= '0;
                    max_q[t][l] <= '0;
                    ptr_q[t][l] <= '0;
                end
            end
        end
        else if (tbl_wr_i)
        begin
            min_q[tbl_wr_sel_i][tbl_wr_len_i] <= tbl_wr_min_i;
            max_q[tbl_wr_sel_i][tbl_wr_len_i] <= tbl_wr_max_i;
            ptr_q[tbl_wr_sel_i][tbl_wr_len_i] <= tbl_wr_ptr_i;
        end
    end

    // ------------------------------
    // Shortest match search
    // ------------------------------
    // Scan from long to short so the shortest hit wins
    always_comb
    begin
        len_r = len_idx_t'(NUM_LENGTHS - 1);
        for (int l = NUM_LENGTHS - 2; l >= 0; l--)
        begin
            if ((lookup_input_i >> (CODE_W - 1 - l)) < max_q[lookup_table_i][l])
                len_r = len_idx_t'(l);
        end
    end

    // Offset into the length's run of symbols
    always_comb
    begin
        top_r  = lookup_input_i >> (CODE_W - 1 - int'(len_r));
        addr_r = top_r - min_q[lookup_table_i][len_r]
               + code_t'(ptr_q[lookup_table_i][len_r]);
    end

    // ------------------------------
    // Request pipeline register
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            lk_valid_q <= 1'b0;
        else
            lk_valid_q <= lookup_req_i;
    end

    always_ff @(posedge clk_i)
    begin
        lk_len_q  <= len_r;
        lk_addr_q <= ptr_t'(addr_r);
    end

    assign lk_valid_o = lk_valid_q;
    assign lk_addr_o  = lk_addr_q;
    assign lk_len_o   = lk_len_q;

endmodule

/* design/dht_symbol_result.sv */
module dht_symbol_result
    import jpeg_dht_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     sym_wr_i,
    input  ptr_t     sym_wr_addr_i,
    input  sym_t     sym_wr_data_i,
    input  logic     lk_valid_i,
    input  ptr_t     lk_addr_i,
    input  len_idx_t lk_len_i,
    output logic     lookup_valid_o,
    output sym_t     lookup_value_o,
    output width_t   lookup_width_o
);

    sym_t   mem [SYM_DEPTH];
    sym_t   value_q;
    logic   valid_q;
    width_t width_q;

    // ------------------------------
    // Symbol RAM
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (sym_wr_i)
            mem[sym_wr_addr_i] <= sym_wr_data_i;
        value_q <= mem[lk_addr_i];
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else
            valid_q <= lk_valid_i;
    end

    // Report the length as 1..16
    always_ff @(posedge clk_i)
    begin
        width_q <= width_t'(lk_len_i) + width_t'(1);
    end

    assign lookup_valid_o = valid_q;
    assign lookup_value_o = value_q;
    assign lookup_width_o = width_q;

endmodule

/* design/jpeg_dht.sv */
module jpeg_dht
    import jpeg_dht_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     cfg_valid_i,
    input  sym_t     cfg_data_i,
    input  logic     cfg_last_i,
    output logic     cfg_accept_o,
    input  logic     lookup_req_i,
    input  tbl_sel_t lookup_table_i,
    input  code_t    lookup_input_i,
    output logic     lookup_valid_o,
    output sym_t     lookup_value_o,
    output width_t   lookup_width_o
);

    // Decode to match
    logic     tbl_wr;
    tbl_sel_t tbl_wr_sel;
    len_idx_t tbl_wr_len;
    code_t    tbl_wr_min;
    code_t    tbl_wr_max;
    ptr_t     tbl_wr_ptr;

    // Decode to result
    logic sym_wr;
    ptr_t sym_wr_addr;
    sym_t sym_wr_data;

    // Match to result
    logic     lk_valid;
    ptr_t     lk_addr;
    len_idx_t lk_len;

    dht_cfg_decode u_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cfg_valid_i   (cfg_valid_i),
        .cfg_data_i    (cfg_data_i),
        .cfg_last_i    (cfg_last_i),
        .cfg_accept_o  (cfg_accept_o),
        .tbl_wr_o      (tbl_wr),
        .tbl_wr_sel_o  (tbl_wr_sel),
        .tbl_wr_len_o  (tbl_wr_len),
        .tbl_wr_min_o  (tbl_wr_min),
        .tbl_wr_max_o  (tbl_wr_max),
        .tbl_wr_ptr_o  (tbl_wr_ptr),
        .sym_wr_o      (sym_wr),
        .sym_wr_addr_o (sym_wr_addr),
        .sym_wr_data_o (sym_wr_data)
    );

    dht_code_match u_match (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .tbl_wr_i       (tbl_wr),
        .tbl_wr_sel_i   (tbl_wr_sel),
        .tbl_wr_len_i   (tbl_wr_len),
        .tbl_wr_min_i   (tbl_wr_min),
        .tbl_wr_max_i   (tbl_wr_max),
        .tbl_wr_ptr_i   (tbl_wr_ptr),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .lk_valid_o     (lk_valid),
        .lk_addr_o      (lk_addr),
        .lk_len_o       (lk_len)
    );

    dht_symbol_result u_result (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .sym_wr_i       (sym_wr),
        .sym_wr_addr_i  (sym_wr_addr),
        .sym_wr_data_i  (sym_wr_data),
        .lk_valid_i     (lk_valid),
        .lk_addr_i      (lk_addr),
        .lk_len_i       (lk_len),
        .lookup_valid_o (lookup_valid_o),
        .lookup_value_o (lookup_value_o),
        .lookup_width_o (lookup_width_o)
    );

endmodule

/* design/jpeg_dht_pkg.sv */
package jpeg_dht_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------
    localparam int CODE_W      = 16;
    localparam int NUM_LENGTHS = 16;
    localparam int SYM_W       = 8;
    localparam int PTR_W       = 10;
    localparam int SYM_DEPTH   = 1 << PTR_W;
    localparam int IDX_W       = 12;

    // Byte index while waiting for a table header
    localparam logic [IDX_W-1:0] IDX_IDLE = '1;

    // DHT header byte (class and id)
    localparam logic [SYM_W-1:0] DHT_ID_Y_DC  = 8'h00;
    localparam logic [SYM_W-1:0] DHT_ID_Y_AC  = 8'h10;
    localparam logic [SYM_W-1:0] DHT_ID_CX_DC = 8'h01;
    localparam logic [SYM_W-1:0] DHT_ID_CX_AC = 8'h11;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [CODE_W-1:0]              code_t;
    typedef logic [SYM_W-1:0]               sym_t;
    typedef logic [PTR_W-1:0]               ptr_t;
    typedef logic [$clog2(NUM_LENGTHS)-1:0] len_idx_t;
    typedef logic [$clog2(NUM_LENGTHS):0]   width_t;

    typedef enum logic [1:0] {
        TBL_Y_DC  = 2'd0,
        TBL_Y_AC  = 2'd1,
        TBL_CX_DC = 2'd2,
        TBL_CX_AC = 2'd3
    } tbl_sel_t;

endpackage

/* jpeg_dht.f */
+incdir+verif
design/jpeg_dht_pkg.sv
design/dht_cfg_decode.sv
design/dht_code_match.sv
design/dht_symbol_result.sv
design/jpeg_dht.sv
verif/jpeg_dht_properties.sv
verif/jpeg_dht_tb.sv

/* verif/jpeg_dht_properties.sv */
module jpeg_dht_properties
    import jpeg_dht_pkg::*;
(
    input logic   clk_i,
    input logic   rst_i,
    input logic   lookup_req_i,
    input logic   lookup_valid_o,
    input width_t lookup_width_o,
    input logic   cfg_accept_o,
    input logic   hdr_wait_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Fixed two cycle lookup latency
    valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        lookup_valid_o == $past(lookup_req_i, 2))
    else
        $error("lookup_valid_o does not follow lookup_req_i by two cycles");

    width_range: assert property (@(posedge clk_i) disable iff (rst_i)
        lookup_valid_o |-> (lookup_width_o >= 1 && lookup_width_o <= 16))
    else
        $error("lookup_width_o outside 1 to 16");

    // Header bytes are never stalled
    header_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        hdr_wait_i |-> cfg_accept_o)
    else
        $error("cfg_accept_o low while waiting for a header byte");

endmodule

bind jpeg_dht jpeg_dht_properties u_props (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .lookup_req_i   (lookup_req_i),
    .lookup_valid_o (lookup_valid_o),
    .lookup_width_o (lookup_width_o),
    .cfg_accept_o   (cfg_accept_o),
    .hdr_wait_i     (u_decode.hdr_w)
);

/* verif/jpeg_dht_tests.svh */
`ifndef JPEG_DHT_TESTS_SVH
`define JPEG_DHT_TESTS_SVH

task automatic check_after_reset();
    @(negedge clk_i);
    assert (!lookup_valid_o)
    else
    begin
        $display("MISMATCH %0t: lookup_valid_o high after reset", $time);
        fail_run();
    end
    assert (cfg_accept_o)
    else
    begin
        $display("MISMATCH %0t: cfg_accept_o low after reset", $time);
        fail_run();
    end
endtask

// One lookup at a time over every code of a table
task automatic lookup_each(input tbl_sel_t tbl);
    for (int e = 0; e < model_n[tbl]; e++)
    begin
        do_lookup(tbl, e);
        end_lookups();
        wait_results();
    end
endtask

// ------------------------------
// Standard luminance DC table
// ------------------------------
task automatic luma_dc_lookups();
    int   counts [NUM_LENGTHS];
    sym_t syms [$];
    counts = '{0, 1, 5, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0};
    for (int i = 0; i < 12; i++)
        syms.push_back(sym_t'(i));
    send_table(DHT_ID_Y_DC, counts, syms, 1'b1);
    end_cfg();
    // Two rounds so each code sees two different tails
    lookup_each(TBL_Y_DC);
    lookup_each(TBL_Y_DC);
endtask

// Chroma DC ends by count, luminance AC by count and cfg_last_i
task automatic two_table_stream();
    int   cx_counts [NUM_LENGTHS];
    int   ac_counts [NUM_LENGTHS];
    sym_t cx_syms [$];
    sym_t ac_syms [$];
    cx_counts = '{0, 3, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0};
    for (int i = 0; i < 12; i++)
        cx_syms.push_back(sym_t'(8'h40 + i));
    // Long run of empty lengths before two 16 bit codes
    ac_counts = '{0, 2, 1, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2};
    ac_syms   = '{8'h01, 8'h02, 8'h03, 8'h11, 8'h04, 8'h21, 8'h05, 8'h31};
    send_table(DHT_ID_CX_DC, cx_counts, cx_syms, 1'b0);
    send_table(DHT_ID_Y_AC, ac_counts, ac_syms, 1'b1);
    end_cfg();
    lookup_each(TBL_CX_DC);
    lookup_each(TBL_Y_AC);
    // First table must be untouched by the later loads
    lookup_each(TBL_Y_DC);
endtask

// ------------------------------
// Pipelined lookups
// ------------------------------
task automatic back_to_back_lookups();
    tbl_sel_t loaded [3];
    tbl_sel_t tbl;
    loaded = '{TBL_Y_DC, TBL_CX_DC, TBL_Y_AC};
    for (int i = 0; i < 36; i++)
    begin
        tbl = loaded[i % 3];
        do_lookup(tbl, i % model_n[tbl]);
    end
    end_lookups();
    wait_results();
endtask

task automatic random_lookups();
    tbl_sel_t loaded [3];
    tbl_sel_t tbl;
    loaded = '{TBL_Y_DC, TBL_CX_DC, TBL_Y_AC};
    for (int i = 0; i < 100; i++)
    begin
        tbl = loaded[rand_below(3)];
        do_lookup(tbl, rand_below(model_n[tbl]));
        // Occasional idle cycle between requests
        if (rand_below(4) == 0)
            end_lookups();
    end
    end_lookups();
    wait_results();
endtask

`endif

/* verif/jpeg_dht_tb.sv */
module jpeg_dht_tb
    import jpeg_dht_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT = 40;
    localparam int RESULT_TIMEOUT = 20;

    logic     clk_i;
    logic     rst_i;
    logic     cfg_valid_i;
    sym_t     cfg_data_i;
    logic     cfg_last_i;
    logic     cfg_accept_o;
    logic     lookup_req_i;
    tbl_sel_t lookup_table_i;
    code_t    lookup_input_i;
    logic     lookup_valid_o;
    sym_t     lookup_value_o;
    width_t   lookup_width_o;

    // Model of the loaded tables, one entry per symbol
    int   model_code [4][256];
    int   model_len  [4][256];
    sym_t model_sym  [4][256];
    int   model_n    [4];

    // Expected results in request order
    sym_t   exp_sym_q   [$];
    width_t exp_width_q [$];
    int     exp_due_q   [$];

    integer seed = 32'hc442b77c;
    int     cyc  = 0;

    jpeg_dht u_jpeg_dht (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_last_i     (cfg_last_i),
        .cfg_accept_o   (cfg_accept_o),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .lookup_valid_o (lookup_valid_o),
        .lookup_value_o (lookup_value_o),
        .lookup_width_o (lookup_width_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------
    // Failure handling
    // ------------------------------
    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        fail_run();
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Header byte to table, per the DHT stream rule
    function automatic tbl_sel_t header_table(input sym_t hdr);
        case (hdr)
            8'h00:   return TBL_Y_DC;
            8'h10:   return TBL_Y_AC;
            8'h01:   return TBL_CX_DC;
            default: return TBL_CX_AC;
        endcase
    endfunction

    // ------------------------------
    // Configuration stream
    // ------------------------------
    // Returns at the negedge before the edge that consumes the byte
    task automatic send_byte(input sym_t data, input logic last);
        int waited;
        waited = 0;
        @(posedge clk_i);
        cfg_valid_i <= 1'b1;
        cfg_data_i  <= data;
        cfg_last_i  <= last;
        @(negedge clk_i);
        while (!cfg_accept_o)
        begin
            waited++;
            if (waited > ACCEPT_TIMEOUT)
                timeout_fail("cfg_accept_o on a symbol byte");
            @(negedge clk_i);
        end
    endtask

    task automatic end_cfg();
        @(posedge clk_i);
        cfg_valid_i <= 1'b0;
        cfg_last_i  <= 1'b0;
    endtask

    // Canonical codes: next code per symbol, double at each new length
    task automatic send_table(input sym_t header, input int counts [NUM_LENGTHS],
                              input sym_t syms [$], input logic last);
        tbl_sel_t tbl;
        int       code;
        int       n;
        tbl  = header_table(header);
        code = 0;
        n    = 0;
        send_byte(header, 1'b0);
        for (int l = 0; l < NUM_LENGTHS; l++)
            send_byte(sym_t'(counts[l]), 1'b0);
        for (int l = 0; l < NUM_LENGTHS; l++)
        begin
            for (int j = 0; j < counts[l]; j++)
            begin
                model_code[tbl][n] = code;
                model_len[tbl][n]  = l + 1;
                model_sym[tbl][n]  = syms[n];
                send_byte(syms[n], last && (n == syms.size() - 1));
                code++;
                n++;
            end
            code = code << 1;
        end
        model_n[tbl] = n;
    endtask

    // ------------------------------
    // Lookups
    // ------------------------------
    // Code left aligned, low bits filled with random tail
    task automatic do_lookup(input tbl_sel_t tbl, input int entry);
        int len;
        int tail;
        int word;
        len  = model_len[tbl][entry];
        tail = $random(seed);
        word = (model_code[tbl][entry] << (CODE_W - len))
             | (tail & ((1 << (CODE_W - len)) - 1));
        @(posedge clk_i);
        lookup_req_i   <= 1'b1;
        lookup_table_i <= tbl;
        lookup_input_i <= code_t'(word);
        exp_sym_q.push_back(model_sym[tbl][entry]);
        exp_width_q.push_back(width_t'(len));
        exp_due_q.push_back(cyc + 2);
    endtask

    task automatic end_lookups();
        @(posedge clk_i);
        lookup_req_i <= 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_due_q.size() != 0)
        begin
            waited++;
            if (waited > RESULT_TIMEOUT)
                timeout_fail("outstanding lookup results");
            @(posedge clk_i);
        end
    endtask

    task automatic check_outputs();
        if (exp_due_q.size() != 0 && exp_due_q[0] == cyc)
        begin
            assert (lookup_valid_o)
            else
            begin
                $display("MISMATCH %0t: lookup_valid_o low when a result was due", $time);
                fail_run();
            end
            assert (lookup_value_o == exp_sym_q[0])
            else
            begin
                $display("MISMATCH %0t: symbol %h, expected %h", $time,
                         lookup_value_o, exp_sym_q[0]);
                fail_run();
            end
            assert (lookup_width_o == exp_width_q[0])
            else
            begin
                $display("MISMATCH %0t: width %0d, expected %0d", $time,
                         lookup_width_o, exp_width_q[0]);
                fail_run();
            end
            void'(exp_sym_q.pop_front());
            void'(exp_width_q.pop_front());
            void'(exp_due_q.pop_front());
        end
        else
        begin
            assert (!lookup_valid_o)
            else
            begin
                $display("MISMATCH %0t: lookup_valid_o high with no request due", $time);
                fail_run();
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_i)
    begin
        if (!rst_i)
            check_outputs();
        cyc = cyc + 1;
    end

    `include "jpeg_dht_tests.svh"

    initial
    begin
        rst_i          = 1'b1;
        cfg_valid_i    = 1'b0;
        cfg_data_i     = '0;
        cfg_last_i     = 1'b0;
        lookup_req_i   = 1'b0;
        lookup_table_i = TBL_Y_DC;
        lookup_input_i = '0;
        for (int t = 0; t < 4; t++)
            model_n[t] = 0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        check_after_reset();
        luma_dc_lookups();
        two_table_stream();
        back_to_back_lookups();
        random_lookups();

        $display("Regression passed");
        $finish;
    end

endmodule
